//--- src/mcpu_pkg.sv
package mcpu_pkg;

    localparam int xlen = 32;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

    typedef enum logic [2:0] {
        st_if,
        st_id,
        st_exe,
        st_mem,
        st_wb
    } state_t;

    // one-hot ALU operation vector with one bit per operation
    typedef logic [11:0] alu_op_t;

    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    typedef enum logic [2:0] {
        br_none,
        br_b,
        br_bl,
        br_jirl,
        br_beq,
        br_bne
    } br_kind_t;

endpackage

//--- src/decode_if.sv
`timescale 1ns/100ps

interface decode_if import mcpu_pkg::*; ();

    alu_op_t         alu_op;
    br_kind_t        br_kind;
    logic            src1_is_pc;
    logic            src2_is_imm;
    logic            res_from_mem;
    logic            gr_we;
    logic            mem_we;
    logic [4:0]      dest;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] br_offs;
    logic [xlen-1:0] rj_value;
    logic [xlen-1:0] rkd_value;

    modport producer (
        output alu_op, br_kind, src1_is_pc, src2_is_imm, res_from_mem, gr_we, mem_we,
        output dest, imm, br_offs, rj_value, rkd_value
    );

    modport exec (
        input br_kind, br_offs, rj_value, rkd_value
    );

    modport ctrl (
        input br_kind, src1_is_pc, src2_is_imm, res_from_mem, gr_we, mem_we,
        input dest, imm, rj_value, rkd_value
    );

endinterface

//--- src/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder import mcpu_pkg::*; (
    input  logic [xlen-1:0] inst,
    output logic [4:0]      rf_raddr1,
    output logic [4:0]      rf_raddr2,
    input  logic [xlen-1:0] rf_rdata1,
    input  logic [xlen-1:0] rf_rdata2,
    decode_if.producer      dec
);

    logic [5:0] op_31_26;
    logic [3:0] op_25_22;
    logic [1:0] op_21_20;
    logic [4:0] op_19_15;
    logic [4:0] rd;
    logic [4:0] rj;
    logic [4:0] rk;
    logic       op_3r;
    logic       op_shift;
    logic       inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic       inst_nor, inst_and, inst_or, inst_xor;
    logic       inst_slli_w, inst_srli_w, inst_srai_w;
    logic       inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic       inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic       need_ui5, need_si12, need_si20, need_si26, src2_is_4;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];

    // three-register ops share one major opcode, shift-immediates another
    assign op_3r    = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign op_shift = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = op_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = op_3r && (op_19_15 == 5'h02);
    assign inst_slt     = op_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = op_3r && (op_19_15 == 5'h05);
    assign inst_nor     = op_3r && (op_19_15 == 5'h08);
    assign inst_and     = op_3r && (op_19_15 == 5'h09);
    assign inst_or      = op_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = op_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = op_shift && (op_19_15 == 5'h01);
    assign inst_srli_w  = op_shift && (op_19_15 == 5'h09);
    assign inst_srai_w  = op_shift && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_ld_w | inst_st_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b | inst_bl;
    // link instructions add 4 to the pc in the ALU
    assign src2_is_4 = inst_jirl | inst_bl;

    always_comb begin
        dec.alu_op           = '0;
        dec.alu_op[alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                             | inst_jirl | inst_bl;
        dec.alu_op[alu_sub]  = inst_sub_w;
        dec.alu_op[alu_slt]  = inst_slt;
        dec.alu_op[alu_sltu] = inst_sltu;
        dec.alu_op[alu_and]  = inst_and;
        dec.alu_op[alu_nor]  = inst_nor;
        dec.alu_op[alu_or]   = inst_or;
        dec.alu_op[alu_xor]  = inst_xor;
        dec.alu_op[alu_sll]  = inst_slli_w;
        dec.alu_op[alu_srl]  = inst_srli_w;
        dec.alu_op[alu_sra]  = inst_srai_w;
        dec.alu_op[alu_lui]  = inst_lu12i_w;
    end

    always_comb begin
        if (inst_b)
            dec.br_kind = br_b;
        else if (inst_bl)
            dec.br_kind = br_bl;
        else if (inst_jirl)
            dec.br_kind = br_jirl;
        else if (inst_beq)
            dec.br_kind = br_beq;
        else if (inst_bne)
            dec.br_kind = br_bne;
        else
            dec.br_kind = br_none;
    end

    always_comb begin
        if (src2_is_4)
            dec.imm = 32'd4;
        else if (need_si20)
            dec.imm = {inst[24:5], 12'b0};
        else if (need_ui5)
            dec.imm = {27'b0, inst[14:10]};
        else if (need_si12)
            dec.imm = {{20{inst[21]}}, inst[21:10]};
        else
            dec.imm = '0;
    end

    // si26 is split across the word with its high bits in [9:0]
    assign dec.br_offs = need_si26 ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                                   : {{14{inst[25]}}, inst[25:10], 2'b0};

    assign dec.src1_is_pc   = inst_jirl | inst_bl;
    assign dec.src2_is_imm  = need_ui5 | need_si12 | need_si20 | src2_is_4;
    assign dec.res_from_mem = inst_ld_w;
    assign dec.gr_we        = ~inst_st_w & ~inst_beq & ~inst_bne & ~inst_b;
    assign dec.mem_we       = inst_st_w;
    assign dec.dest         = inst_bl ? 5'd1 : rd;

    // compares and stores take their second operand from rd
    assign rf_raddr1     = rj;
    assign rf_raddr2     = (inst_beq | inst_bne | inst_st_w) ? rd : rk;
    assign dec.rj_value  = rf_rdata1;
    assign dec.rkd_value = rf_rdata2;

endmodule

//--- src/regfile.sv
`timescale 1ns/100ps

module regfile import mcpu_pkg::*; (
    input  logic            clk,
    input  logic [4:0]      raddr1,
    input  logic [4:0]      raddr2,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata
);

    logic [xlen-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, whatever was written into its slot
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- src/alu.sv
`timescale 1ns/100ps

module alu import mcpu_pkg::*; (
    input  alu_op_t         alu_op,
    input  logic [xlen-1:0] alu_src1,
    input  logic [xlen-1:0] alu_src2,
    output logic [xlen-1:0] alu_result
);

    logic [xlen-1:0] add_res;
    logic [xlen-1:0] sub_res;
    logic [xlen-1:0] slt_res;
    logic [xlen-1:0] sltu_res;
    logic [xlen-1:0] sll_res;
    logic [xlen-1:0] srl_res;
    logic [xlen-1:0] sra_res;
    logic [4:0]      shamt;

    assign shamt    = alu_src2[4:0];
    assign add_res  = alu_src1 + alu_src2;
    assign sub_res  = alu_src1 - alu_src2;
    assign slt_res  = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
    assign sltu_res = {31'b0, alu_src1 < alu_src2};
    assign sll_res  = alu_src1 << shamt;
    assign srl_res  = alu_src1 >> shamt;
    assign sra_res  = $signed(alu_src1) >>> shamt;

    // the op vector is one-hot so the terms can simply be OR-ed
    assign alu_result = ({xlen{alu_op[alu_add]}}  & add_res)
                      | ({xlen{alu_op[alu_sub]}}  & sub_res)
                      | ({xlen{alu_op[alu_slt]}}  & slt_res)
                      | ({xlen{alu_op[alu_sltu]}} & sltu_res)
                      | ({xlen{alu_op[alu_and]}}  & (alu_src1 & alu_src2))
                      | ({xlen{alu_op[alu_nor]}}  & ~(alu_src1 | alu_src2))
                      | ({xlen{alu_op[alu_or]}}   & (alu_src1 | alu_src2))
                      | ({xlen{alu_op[alu_xor]}}  & (alu_src1 ^ alu_src2))
                      | ({xlen{alu_op[alu_sll]}}  & sll_res)
                      | ({xlen{alu_op[alu_srl]}}  & srl_res)
                      | ({xlen{alu_op[alu_sra]}}  & sra_res)
                      | ({xlen{alu_op[alu_lui]}}  & alu_src2);

endmodule

//--- src/branch_unit.sv
`timescale 1ns/100ps

module branch_unit import mcpu_pkg::*; (
    decode_if.exec          dec,
    input  logic [xlen-1:0] pc,
    output logic            br_taken,
    output logic [xlen-1:0] br_target
);

    logic rj_eq_rd;

    assign rj_eq_rd = (dec.rj_value == dec.rkd_value);

    always_comb begin
        case (dec.br_kind)
            br_b, br_bl, br_jirl: br_taken = 1'b1;
            br_beq:               br_taken = rj_eq_rd;
            br_bne:               br_taken = !rj_eq_rd;
            default:              br_taken = 1'b0;
        endcase
    end

    // jirl is register relative, everything else is pc relative
    assign br_target = (dec.br_kind == br_jirl) ? dec.rj_value + dec.br_offs
                                                : pc + dec.br_offs;

endmodule

//--- src/mcpu_ctrl.sv
`timescale 1ns/100ps

module mcpu_ctrl import mcpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    output logic [xlen-1:0] inst_sram_addr,
    input  logic [xlen-1:0] inst_sram_rdata,
    output logic [xlen-1:0] inst_q,
    decode_if.ctrl          dec,
    input  logic            br_taken,
    input  logic [xlen-1:0] br_target,
    output logic [xlen-1:0] alu_src1,
    output logic [xlen-1:0] alu_src2,
    input  logic [xlen-1:0] alu_result,
    output logic            data_sram_we,
    output logic [xlen-1:0] data_sram_addr,
    output logic [xlen-1:0] data_sram_wdata,
    input  logic [xlen-1:0] data_sram_rdata,
    output logic            rf_we,
    output logic [4:0]      rf_waddr,
    output logic [xlen-1:0] rf_wdata,
    output logic [xlen-1:0] debug_wb_pc,
    output logic [3:0]      debug_wb_rf_we,
    output logic [4:0]      debug_wb_rf_wnum,
    output logic [xlen-1:0] debug_wb_rf_wdata
);

    state_t          state;
    state_t          state_nxt;
    logic [xlen-1:0] pc;
    logic            gr_we_q;
    logic            mem_we_q;
    logic            res_from_mem_q;
    logic [4:0]      dest_q;
    logic [xlen-1:0] src1_q;
    logic [xlen-1:0] src2_q;
    logic [xlen-1:0] store_q;
    logic [xlen-1:0] wb_pc_q;
    logic [xlen-1:0] mem_q;
    logic [xlen-1:0] wb_value;

    always_comb begin
        case (state)
            st_if:   state_nxt = st_id;
            st_id:   state_nxt = (dec.br_kind inside {br_b, br_beq, br_bne}) ? st_if : st_exe;
            st_exe:  state_nxt = (mem_we_q || res_from_mem_q) ? st_mem : st_wb;
            st_mem:  state_nxt = res_from_mem_q ? st_wb : st_if;
            st_wb:   state_nxt = st_if;
            default: state_nxt = st_if;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= st_if;
            pc             <= reset_pc;
            gr_we_q        <= 1'b0;
            mem_we_q       <= 1'b0;
            res_from_mem_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == st_id) begin
                pc             <= br_taken ? br_target : pc + 32'd4;
                gr_we_q        <= dec.gr_we;
                mem_we_q       <= dec.mem_we;
                res_from_mem_q <= dec.res_from_mem;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_if) begin
            inst_q <= inst_sram_rdata;
        end
        // pc moves on at the end of decode, so its old value is kept for the trace
        if (state == st_id) begin
            src1_q  <= dec.src1_is_pc ? pc : dec.rj_value;
            src2_q  <= dec.src2_is_imm ? dec.imm : dec.rkd_value;
            store_q <= dec.rkd_value;
            dest_q  <= dec.dest;
            wb_pc_q <= pc;
        end
        if (state == st_mem) begin
            mem_q <= data_sram_rdata;
        end
    end

    assign inst_sram_addr = pc;
    assign alu_src1       = src1_q;
    assign alu_src2       = src2_q;

    assign data_sram_we    = (state == st_mem) && mem_we_q;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = store_q;

    // r0 is hardwired so a write to it traces as zero
    assign wb_value = (dest_q == 5'd0) ? '0 : (res_from_mem_q ? mem_q : alu_result);

    assign rf_we    = (state == st_wb) && gr_we_q;
    assign rf_waddr = dest_q;
    assign rf_wdata = wb_value;

    assign debug_wb_pc       = wb_pc_q;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest_q;
    assign debug_wb_rf_wdata = wb_value;

endmodule

//--- src/mcpu_top.sv
`timescale 1ns/100ps

module mcpu_top import mcpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    output logic            inst_sram_we,
    output logic [xlen-1:0] inst_sram_addr,
    output logic [xlen-1:0] inst_sram_wdata,
    input  logic [xlen-1:0] inst_sram_rdata,
    output logic            data_sram_we,
    output logic [xlen-1:0] data_sram_addr,
    output logic [xlen-1:0] data_sram_wdata,
    input  logic [xlen-1:0] data_sram_rdata,
    output logic [xlen-1:0] debug_wb_pc,
    output logic [3:0]      debug_wb_rf_we,
    output logic [4:0]      debug_wb_rf_wnum,
    output logic [xlen-1:0] debug_wb_rf_wdata
);

    logic [xlen-1:0] inst_q;
    logic [xlen-1:0] pc;
    logic [4:0]      rf_raddr1;
    logic [4:0]      rf_raddr2;
    logic [xlen-1:0] rf_rdata1;
    logic [xlen-1:0] rf_rdata2;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [xlen-1:0] rf_wdata;
    logic [xlen-1:0] alu_src1;
    logic [xlen-1:0] alu_src2;
    logic [xlen-1:0] alu_result;
    logic            br_taken;
    logic [xlen-1:0] br_target;

    // the instruction port is fetch only
    assign inst_sram_we    = 1'b0;
    assign inst_sram_wdata = '0;
    assign pc              = inst_sram_addr;

    decode_if dec_bus ();

    inst_decoder u_inst_decoder (
        .inst      (inst_q),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .dec       (dec_bus.producer)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // inst_q holds through exe, so the decoded op stays valid for the ALU
    alu u_alu (
        .alu_op     (dec_bus.alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    branch_unit u_branch_unit (
        .dec       (dec_bus.exec),
        .pc        (pc),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    mcpu_ctrl u_mcpu_ctrl (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .inst_q            (inst_q),
        .dec               (dec_bus.ctrl),
        .br_taken          (br_taken),
        .br_target         (br_target),
        .alu_src1          (alu_src1),
        .alu_src2          (alu_src2),
        .alu_result        (alu_result),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

//--- dv/mcpu_sva.sv
`timescale 1ns/100ps

module mcpu_sva import mcpu_pkg::*; (
    input logic            clk,
    input logic            reset,
    input state_t          state,
    input logic            data_sram_we,
    input logic            rf_we,
    input logic [4:0]      rf_waddr,
    input logic [xlen-1:0] debug_wb_rf_wdata
);

    // the store strobe belongs to the memory step only
    assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> (state == st_mem))
        else $error("data_sram_we high outside st_mem");

    assert property (@(posedge clk) disable iff (reset)
        (rf_we && rf_waddr == 5'd0) |-> (debug_wb_rf_wdata == '0))
        else $error("write to r0 traced a nonzero value");

    // decode leads back to fetch or on to execute
    assert property (@(posedge clk) disable iff (reset)
        (state == st_id) |=> (state == st_if || state == st_exe))
        else $error("st_id not followed by st_if or st_exe");

endmodule

bind mcpu_ctrl mcpu_sva u_mcpu_sva (
    .clk               (clk),
    .reset             (reset),
    .state             (state),
    .data_sram_we      (data_sram_we),
    .rf_we             (rf_we),
    .rf_waddr          (rf_waddr),
    .debug_wb_rf_wdata (debug_wb_rf_wdata)
);

//--- dv/mcpu_tb.sv
`timescale 1ns/100ps

module mcpu_tb;

    // word offsets of the sections inside the stimulus image
    localparam int data_base  = 'h40;
    localparam int wb_base    = 'h50;
    localparam int store_base = 'ha0;

    logic        clk;
    logic        reset;
    logic        inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] stim [0:255];
    logic [31:0] dmem [0:15];
    int          wb_cnt;
    int          wb_idx;
    int          store_cnt;
    int          store_idx;

    mcpu_top dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #4 clk = ~clk;

    // the program sits at the start of the image, so the low pc bits index it
    assign inst_sram_rdata = stim[{2'b00, inst_sram_addr[7:2]}];
    assign data_sram_rdata = dmem[data_sram_addr[5:2]];

    // the data memory takes stores on the clock edge
    always @(posedge clk) begin
        if (!reset && data_sram_we) begin
            dmem[data_sram_addr[5:2]] <= data_sram_wdata;
        end
    end

    function automatic logic [31:0] stim_word(input int addr);
        return stim[addr[7:0]];
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
            else abort_run($sformatf("ERR time %0t %s expected %08h actual %08h",
                                     $time, name, expected, actual));
    endtask

    task automatic wait_for_activity();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (debug_wb_rf_we == 4'h0 && !data_sram_we && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        assert (debug_wb_rf_we != 4'h0 || data_sram_we)
            else abort_run($sformatf("timeout waiting for writeback %0d or store %0d",
                                     wb_idx, store_idx));
    endtask

    task automatic check_writeback();
        int entry;
        assert (wb_idx < wb_cnt)
            else abort_run("writeback pulse after the expected list was used up");
        entry = wb_base + 1 + 3 * wb_idx;
        check_value("debug_wb_rf_we", 32'hf, {28'h0, debug_wb_rf_we});
        check_value("debug_wb_pc", stim_word(entry), debug_wb_pc);
        check_value("debug_wb_rf_wnum", stim_word(entry + 1), {27'h0, debug_wb_rf_wnum});
        check_value("debug_wb_rf_wdata", stim_word(entry + 2), debug_wb_rf_wdata);
        wb_idx++;
    endtask

    task automatic check_store();
        int entry;
        assert (store_idx < store_cnt)
            else abort_run("store after the expected store list was used up");
        entry = store_base + 1 + 2 * store_idx;
        check_value("data_sram_addr", stim_word(entry), data_sram_addr);
        check_value("data_sram_wdata", stim_word(entry + 1), data_sram_wdata);
        store_idx++;
    endtask

    // the program ends in a branch to itself, which must stay silent
    task automatic check_quiet();
        repeat (40) begin
            @(negedge clk);
            assert (debug_wb_rf_we == 4'h0)
                else abort_run("writeback pulse after both expected lists were used up");
            assert (!data_sram_we)
                else abort_run("store after both expected lists were used up");
            check_value("inst_sram_we", 32'h0, {31'h0, inst_sram_we});
            check_value("inst_sram_wdata", 32'h0, inst_sram_wdata);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        wb_idx    = 0;
        store_idx = 0;
        $readmemh("dv/mcpu_stimulus.hex", stim);
        for (int i = 0; i < 16; i++) begin
            dmem[i] = stim_word(data_base + i);
        end
        wb_cnt    = int'(stim_word(wb_base));
        store_cnt = int'(stim_word(store_base));

        repeat (7) @(posedge clk);
        @(negedge clk);
        check_value("inst_sram_addr", 32'h1c00_0000, inst_sram_addr);
        check_value("data_sram_we", 32'h0, {31'h0, data_sram_we});
        check_value("debug_wb_rf_we", 32'h0, {28'h0, debug_wb_rf_we});
        @(posedge clk);
        reset <= 1'b0;

        while (wb_idx < wb_cnt || store_idx < store_cnt) begin
            wait_for_activity();
            if (debug_wb_rf_we != 4'h0) begin
                check_writeback();
            end else begin
                check_store();
            end
        end
        check_quiet();

        $display("Test OK");
        $finish;
    end

endmodule

//--- mcpu_top.f
src/mcpu_pkg.sv
src/decode_if.sv
src/inst_decoder.sv
src/regfile.sv
src/alu.sv
src/branch_unit.sv
src/mcpu_ctrl.sv
src/mcpu_top.sv
dv/mcpu_sva.sv
dv/mcpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds mcpu_tb with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mcpu_tb -f mcpu_top.f -o mcpu_sim \
    && ./obj_dir/mcpu_sim 2>&1 | tee sim.log \
    && grep -qx "Test OK" sim.log \
    || { echo "simulation did not pass"; exit 1; }

//--- dv/mcpu_stimulus.hex
// one 32-bit word per entry: @000 program, @040 data words 0..15
// @050 writeback count then pc, register, value; @0a0 store count then address, data
@000
142468a4 // lu12i.w r4, 0x12345
0299e084 // addi.w  r4, r4, 0x678
02bff405 // addi.w  r5, r0, -3
00101486 // add.w   r6, r4, r5
001110a7 // sub.w   r7, r5, r4
001210a8 // slt     r8, r5, r4
001290a9 // sltu    r9, r5, r4
0014148a // nor     r10, r4, r5
0014948b // and     r11, r4, r5
0015208c // or      r12, r4, r8
0015948d // xor     r13, r4, r5
0040908e // slli.w  r14, r4, 4
0044a0af // srli.w  r15, r5, 8
004890f0 // srai.w  r16, r7, 4
02804014 // addi.w  r20, r0, 0x10
29802286 // st.w    r6, r20, 8
28802295 // ld.w    r21, r20, 8
28bff296 // ld.w    r22, r20, -4
58000aa6 // beq     r21, r6, +8 (taken)
02800417 // addi.w  r23, r0, 1 (skipped)
5c000aa6 // bne     r21, r6, +8 (not taken)
02800817 // addi.w  r23, r0, 2
58000885 // beq     r4, r5, +8 (not taken)
5c000885 // bne     r4, r5, +8 (taken)
02800c17 // addi.w  r23, r0, 3 (skipped)
50000800 // b       +8
02801017 // addi.w  r23, r0, 4 (skipped)
54000c00 // bl      +12
02801418 // addi.w  r24, r0, 5 (skipped)
02801818 // addi.w  r24, r0, 6 (skipped)
4c001039 // jirl    r25, r1, 16
02801c18 // addi.w  r24, r0, 7 (skipped)
02800080 // addi.w  r0, r4, 0
0010141a // add.w   r26, r0, r5
2980029a // st.w    r26, r20, 0
50000000 // b       0
@040
a0000000 a1000001 a2000002 a3000003
a4000004 a5000005 a6000006 a7000007
a8000008 a9000009 aa00000a ab00000b
ac00000c ad00000d ae00000e af00000f
@050
00000016
1c000000 00000004 12345000
1c000004 00000004 12345678
1c000008 00000005 fffffffd
1c00000c 00000006 12345675
1c000010 00000007 edcba985
1c000014 00000008 00000001
1c000018 00000009 00000000
1c00001c 0000000a 00000002
1c000020 0000000b 12345678
1c000024 0000000c 12345679
1c000028 0000000d edcba985
1c00002c 0000000e 23456780
1c000030 0000000f 00ffffff
1c000034 00000010 fedcba98
1c000038 00000014 00000010
1c000040 00000015 12345675
1c000044 00000016 a3000003
1c000054 00000017 00000002
1c00006c 00000001 1c000070
1c000078 00000019 1c00007c
1c000080 00000000 00000000
1c000084 0000001a fffffffd
@0a0
00000002
00000018 12345675
00000010 fffffffd
